// File: hw/irq_pkg.sv
package irq_pkg;

  // ----------------------------------------------------------------------
  // Interrupt line constants
  // ----------------------------------------------------------------------

  localparam int NUM_IRQ = 32;

  // Implemented lines are the fast interrupts 31..16, MEI, MTI and MSI
  localparam logic [NUM_IRQ-1:0] VALID_IRQ_MASK = 32'hffff_0888;

  // Index of one interrupt line
  typedef logic [4:0] irq_id_t;

  // ----------------------------------------------------------------------
  // Privilege and CSR view
  // ----------------------------------------------------------------------

  // Encoding follows the RISC-V privilege spec
  typedef enum logic [1:0] {
    priv_u = 2'b00,
    priv_m = 2'b11
  } priv_lvl_e;

  // CSR fields the interrupt logic depends on
  typedef struct packed {
    logic [NUM_IRQ-1:0] mie;
    logic               mstatus_mie;
    logic               mstatus_tw;
    priv_lvl_e          priv_lvl;
  } csr_state_t;

  // ----------------------------------------------------------------------
  // Interrupt take notice to the core
  // ----------------------------------------------------------------------

  // Ack is a single-cycle pulse; id is only meaningful while ack is high
  typedef struct packed {
    logic    ack;
    irq_id_t id;
  } irq_take_t;

endpackage

// File: hw/sleep_pkg.sv
package sleep_pkg;

  // ----------------------------------------------------------------------
  // Opcodes and timing
  // ----------------------------------------------------------------------

  localparam logic [31:0] WFI_INSTR = 32'h1050_0073;
  localparam logic [31:0] WFE_INSTR = 32'h8C00_0073;

  // Saturating count of edges a qualified WFI/WFE has spent in writeback
  typedef logic [1:0] residency_t;

  // Residency needed before sleep may be entered
  localparam residency_t SLEEP_ENTRY_DELAY = 2'd2;

  // ----------------------------------------------------------------------
  // Writeback stage and bus status
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
    logic        err;
    logic        mpu_ok;
    logic        kill;
  } wb_instr_t;

  // Outstanding counts of the instruction and data OBI ports
  typedef struct packed {
    logic [1:0] instr_outstanding;
    logic [1:0] data_outstanding;
    logic       wbuf_empty;
  } bus_status_t;

  // ----------------------------------------------------------------------
  // Wake sources and WFI state
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic debug_req;
    logic nmi;
    logic trigger;
    logic wu_wfe;
  } wake_req_t;

  typedef struct packed {
    logic       in_wb;
    logic       is_wfe;
    residency_t residency;
  } wfi_state_t;

endpackage

// File: hw/irq_arbiter.sv
`timescale 1ns/1ps

module irq_arbiter (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic [irq_pkg::NUM_IRQ-1:0] irq_i,
  input  irq_pkg::csr_state_t         csr_i,
  input  logic                        debug_mode_i,
  output logic [irq_pkg::NUM_IRQ-1:0] mip_o,
  output logic                        irq_pending_o,
  output irq_pkg::irq_take_t          take_o
);

  logic [irq_pkg::NUM_IRQ-1:0] mip_q;
  logic [irq_pkg::NUM_IRQ-1:0] pend_en;
  logic                        win_valid;
  irq_pkg::irq_id_t            win_id;
  logic                        priv_ok;
  logic                        take_en;
  logic                        ack_q;
  irq_pkg::irq_id_t            id_q;

  // ----------------------------------------------------------------------
  // Pending register
  // ----------------------------------------------------------------------

  // Reserved lines never reach mip
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & irq_pkg::VALID_IRQ_MASK;
    end
  end

  assign pend_en       = mip_q & csr_i.mie;
  assign irq_pending_o = |pend_en;
  assign mip_o         = mip_q;

  // ----------------------------------------------------------------------
  // Fixed priority from 31 down to 16, then 11, 3 and 7
  // ----------------------------------------------------------------------

  always_comb begin
    win_valid = 1'b0;
    win_id    = '0;
    // Walk from lowest to highest priority so later hits override
    if (pend_en[7]) begin
      win_valid = 1'b1;
      win_id    = 5'd7;
    end
    if (pend_en[3]) begin
      win_valid = 1'b1;
      win_id    = 5'd3;
    end
    if (pend_en[11]) begin
      win_valid = 1'b1;
      win_id    = 5'd11;
    end
    for (int i = 16; i < irq_pkg::NUM_IRQ; i++) begin
      if (pend_en[i]) begin
        win_valid = 1'b1;
        win_id    = irq_pkg::irq_id_t'(i);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Take decision
  // ----------------------------------------------------------------------

  // U-mode interrupts are always taken into M-mode
  assign priv_ok = ((csr_i.priv_lvl == irq_pkg::priv_m) && csr_i.mstatus_mie) ||
                   (csr_i.priv_lvl == irq_pkg::priv_u);

  // A cycle after an ack is blocked so the core can update mstatus or the line
  assign take_en = win_valid && !ack_q && !debug_mode_i && priv_ok;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= take_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_en) begin
      id_q <= win_id;
    end
  end

  assign take_o.ack = ack_q;
  assign take_o.id  = id_q;

endmodule

// File: hw/wfi_qualify.sv
`timescale 1ns/1ps

module wfi_qualify (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  sleep_pkg::wb_instr_t  wb_i,
  input  irq_pkg::csr_state_t   csr_i,
  input  logic                  debug_mode_i,
  output sleep_pkg::wfi_state_t wfi_state_o
);

  logic                  is_wfi_op;
  logic                  is_wfe_op;
  logic                  tw_trap;
  logic                  qualified;
  sleep_pkg::residency_t residency_q;

  // ----------------------------------------------------------------------
  // Qualification of the writeback instruction
  // ----------------------------------------------------------------------

  assign is_wfi_op = (wb_i.rdata == sleep_pkg::WFI_INSTR);
  assign is_wfe_op = (wb_i.rdata == sleep_pkg::WFE_INSTR);

  // WFI in U-mode with mstatus.TW set traps instead of sleeping
  assign tw_trap = (csr_i.priv_lvl == irq_pkg::priv_u) && csr_i.mstatus_tw;

  assign qualified = wb_i.valid &&
                     (is_wfi_op || is_wfe_op) &&
                     !wb_i.err &&
                     wb_i.mpu_ok &&
                     !wb_i.kill &&
                     !debug_mode_i &&
                     !tw_trap;

  // ----------------------------------------------------------------------
  // Residency counter
  // ----------------------------------------------------------------------

  // Counts consecutive qualified edges and holds at 3
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      residency_q <= '0;
    end else if (!qualified) begin
      residency_q <= '0;
    end else if (residency_q != 2'd3) begin
      residency_q <= residency_q + 2'd1;
    end
  end

  assign wfi_state_o.in_wb     = qualified;
  assign wfi_state_o.is_wfe    = qualified && is_wfe_op;
  assign wfi_state_o.residency = residency_q;

endmodule

// File: hw/sleep_ctrl.sv
`timescale 1ns/1ps

module sleep_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  sleep_pkg::wfi_state_t  wfi_state_i,
  input  sleep_pkg::bus_status_t bus_i,
  input  sleep_pkg::wake_req_t   wake_i,
  input  logic                   irq_pending_i,
  output logic                   core_sleep_o,
  output logic                   wfi_retire_o
);

  logic [1:0] instr_out_q;
  logic [1:0] data_out_q;
  logic       bus_busy_now;
  logic       bus_busy_prev;
  logic       blocked;
  logic       wfe_wake;
  logic       wake;
  logic       entry_ok;
  logic       sleep_d;
  logic       sleep_q;

  // ----------------------------------------------------------------------
  // Bus idle history
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_out_q <= '0;
      data_out_q  <= '0;
    end else begin
      instr_out_q <= bus_i.instr_outstanding;
      data_out_q  <= bus_i.data_outstanding;
    end
  end

  assign bus_busy_now  = |bus_i.instr_outstanding || |bus_i.data_outstanding;
  assign bus_busy_prev = |instr_out_q || |data_out_q;

  // A count seen in the last cycle still blocks, since its response may be in flight
  assign blocked = bus_busy_now || bus_busy_prev || !bus_i.wbuf_empty;

  // ----------------------------------------------------------------------
  // Wake sources
  // ----------------------------------------------------------------------

  // The WFE wake-up event is ignored by a plain WFI
  assign wfe_wake = wake_i.wu_wfe && wfi_state_i.is_wfe;

  assign wake = irq_pending_i ||
                wake_i.debug_req ||
                wake_i.nmi ||
                wake_i.trigger ||
                wfe_wake;

  // ----------------------------------------------------------------------
  // Sleep state
  // ----------------------------------------------------------------------

  assign entry_ok = wfi_state_i.residency >= sleep_pkg::SLEEP_ENTRY_DELAY;

  // Entry and stay share one condition; any wake, block or lost WFI drops it
  assign sleep_d = wfi_state_i.in_wb && entry_ok && !wake && !blocked;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sleep_q <= 1'b0;
    end else begin
      sleep_q <= sleep_d;
    end
  end

  assign core_sleep_o = sleep_q;

  // WFI/WFE leaves writeback in the cycle its wake is seen
  assign wfi_retire_o = wfi_state_i.in_wb && wake;

endmodule

// File: hw/irq_sleep_unit.sv
`timescale 1ns/1ps

module irq_sleep_unit (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // Interrupt lines and CSR state
  input  logic [irq_pkg::NUM_IRQ-1:0] irq_i,
  input  irq_pkg::csr_state_t         csr_i,
  input  logic                        debug_mode_i,

  // Writeback, bus and wake inputs
  input  sleep_pkg::wb_instr_t        wb_i,
  input  sleep_pkg::bus_status_t      bus_i,
  input  sleep_pkg::wake_req_t        wake_i,

  // Results to the core
  output irq_pkg::irq_take_t          take_o,
  output logic [irq_pkg::NUM_IRQ-1:0] mip_o,
  output logic                        core_sleep_o,
  output logic                        wfi_retire_o
);

  logic                  irq_pending;
  sleep_pkg::wfi_state_t wfi_state;

  // ----------------------------------------------------------------------
  // Interrupt capture and arbitration
  // ----------------------------------------------------------------------

  irq_arbiter u_irq_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .irq_i         (irq_i),
    .csr_i         (csr_i),
    .debug_mode_i  (debug_mode_i),
    .mip_o         (mip_o),
    .irq_pending_o (irq_pending),
    .take_o        (take_o)
  );

  // ----------------------------------------------------------------------
  // WFI/WFE detection in writeback
  // ----------------------------------------------------------------------

  wfi_qualify u_wfi_qualify (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_i         (wb_i),
    .csr_i        (csr_i),
    .debug_mode_i (debug_mode_i),
    .wfi_state_o  (wfi_state)
  );

  // ----------------------------------------------------------------------
  // Sleep entry, wake and retirement
  // ----------------------------------------------------------------------

  sleep_ctrl u_sleep_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wfi_state_i   (wfi_state),
    .bus_i         (bus_i),
    .wake_i        (wake_i),
    .irq_pending_i (irq_pending),
    .core_sleep_o  (core_sleep_o),
    .wfi_retire_o  (wfi_retire_o)
  );

endmodule

// File: tb/irq_sleep_tasks.svh
  // ----------------------------------------------------------------------
  // Random numbers
  // ----------------------------------------------------------------------

  // 32-bit xorshift over rng_state
  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Step n edges and check the sleep state after each
  task automatic expect_sleep(input int n, input logic exp);
    repeat (n) begin
      tick(1);
      check_val("core_sleep_o", core_sleep_o, exp);
    end
  endtask

  task automatic present_wfi(input logic [31:0] opcode);
    wb_i.valid  = 1'b1;
    wb_i.rdata  = opcode;
    wb_i.err    = 1'b0;
    wb_i.mpu_ok = 1'b1;
    wb_i.kill   = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Interrupt tests
  // ----------------------------------------------------------------------

  task automatic test_pending_capture();
    logic [31:0] lines;
    int          i;
    for (i = 0; i < 40; i++) begin
      lines = next_rand();
      irq_i = lines;
      tick(1);
      check_val("mip_o", mip_o, lines & irq_pkg::VALID_IRQ_MASK);
      check_val("mip_o reserved", mip_o & ~irq_pkg::VALID_IRQ_MASK, 32'h0);
    end
    irq_i = '0;
    tick(1);
    end_test("pending_capture");
  endtask

  task automatic test_arbitration();
    logic [31:0] lines;
    logic [31:0] enables;
    logic [5:0]  exp;
    int          i;
    for (i = 0; i < 40; i++) begin
      lines   = next_rand();
      enables = next_rand() & next_rand();
      // Some patterns leave only 11, 3 and 7 to compete
      if (i % 4 == 1) begin
        lines = lines & 32'h0000_ffff;
      end
      if (i % 8 == 0) begin
        enables = ~lines;
      end
      exp               = ref_winner(lines & irq_pkg::VALID_IRQ_MASK & enables);
      irq_i             = lines;
      csr_i.mie         = enables;
      csr_i.mstatus_mie = 1'b1;
      tick(1);
      check_val("take_o.ack", take_o.ack, 32'h0);
      tick(1);
      check_val("take_o.ack", take_o.ack, exp[5]);
      if (exp[5]) begin
        check_val("take_o.id", take_o.id, exp[4:0]);
      end
      // The core reacts to the take by clearing its enables
      irq_i             = '0;
      csr_i.mie         = '0;
      csr_i.mstatus_mie = 1'b0;
      tick(2);
    end
    end_test("arbitration");
  endtask

  task automatic test_gating();
    logic prev_ack;
    int   acks;
    int   i;
    irq_i     = 32'h0000_0808;
    csr_i.mie = 32'hffff_ffff;
    for (i = 0; i < 6; i++) begin
      tick(1);
      check_val("take_o.ack", take_o.ack, 32'h0);
    end
    // Lines are already pending, so U-mode takes at the next edge
    csr_i.priv_lvl = irq_pkg::priv_u;
    tick(1);
    check_val("take_o.ack", take_o.ack, 32'h1);
    check_val("take_o.id", take_o.id, 32'd11);
    csr_i.priv_lvl    = irq_pkg::priv_m;
    csr_i.mstatus_mie = 1'b1;
    debug_mode_i      = 1'b1;
    for (i = 0; i < 6; i++) begin
      tick(1);
      check_val("take_o.ack", take_o.ack, 32'h0);
    end
    debug_mode_i = 1'b0;
    prev_ack     = 1'b0;
    acks         = 0;
    for (i = 0; i < 12; i++) begin
      tick(1);
      assert (!(prev_ack && take_o.ack))
      else begin
        $display("Acknowledge was high on two consecutive cycles at %0t", $time);
        test_errors++;
      end
      acks += take_o.ack;
      prev_ack = take_o.ack;
    end
    assert (acks > 0)
    else begin
      $display("No acknowledge was seen while an enabled line was held");
      test_errors++;
    end
    drive_idle();
    tick(2);
    end_test("gating");
  endtask

  // ----------------------------------------------------------------------
  // Sleep tests
  // ----------------------------------------------------------------------

  task automatic test_sleep_entry();
    int i;
    present_wfi(sleep_pkg::WFI_INSTR);
    expect_sleep(2, 1'b0);
    expect_sleep(1, 1'b1);
    drive_idle();
    expect_sleep(1, 1'b0);
    // Kill, error, TW trap and debug mode each block qualification
    for (i = 0; i < 4; i++) begin
      present_wfi(sleep_pkg::WFI_INSTR);
      case (i)
        0: wb_i.kill = 1'b1;
        1: wb_i.err = 1'b1;
        2: begin
          csr_i.priv_lvl   = irq_pkg::priv_u;
          csr_i.mstatus_tw = 1'b1;
        end
        default: debug_mode_i = 1'b1;
      endcase
      expect_sleep(8, 1'b0);
      drive_idle();
      tick(1);
    end
    end_test("sleep_entry");
  endtask

  task automatic test_back_pressure();
    present_wfi(sleep_pkg::WFI_INSTR);
    bus_i.data_outstanding = 2'd2;
    expect_sleep(6, 1'b0);
    bus_i.data_outstanding = 2'd0;
    // Last cycle's count still blocks at the first idle edge
    expect_sleep(1, 1'b0);
    expect_sleep(1, 1'b1);
    drive_idle();
    expect_sleep(1, 1'b0);
    present_wfi(sleep_pkg::WFI_INSTR);
    bus_i.wbuf_empty = 1'b0;
    expect_sleep(6, 1'b0);
    bus_i.wbuf_empty = 1'b1;
    expect_sleep(1, 1'b1);
    drive_idle();
    expect_sleep(1, 1'b0);
    end_test("back_pressure");
  endtask

  // Sleep on a WFI or WFE, then raise one wake source
  task automatic wake_case(input int src, input logic wfe, input logic wakes);
    drive_idle();
    // MEI pending but masked until the irq source unmasks it
    irq_i = 32'h0000_0800;
    present_wfi(wfe ? sleep_pkg::WFE_INSTR : sleep_pkg::WFI_INSTR);
    expect_sleep(2, 1'b0);
    expect_sleep(1, 1'b1);
    case (src)
      0: csr_i.mie[11] = 1'b1;
      1: wake_i.debug_req = 1'b1;
      2: wake_i.nmi = 1'b1;
      3: wake_i.trigger = 1'b1;
      default: wake_i.wu_wfe = 1'b1;
    endcase
    #1;
    check_val("wfi_retire_o", wfi_retire_o, wakes);
    check_val("core_sleep_o", core_sleep_o, 32'h1);
    expect_sleep(3, !wakes);
    drive_idle();
    tick(1);
    check_val("wfi_retire_o", wfi_retire_o, 32'h0);
    check_val("core_sleep_o", core_sleep_o, 32'h0);
  endtask

  task automatic test_wake_retire();
    int src;
    for (src = 0; src < 4; src++) begin
      wake_case(src, 1'b0, 1'b1);
    end
    wake_case(4, 1'b1, 1'b1);
    wake_case(4, 1'b0, 1'b0);
    end_test("wake_retire");
  endtask

// File: tb/irq_sleep_tb.sv
`timescale 1ns/1ps

module irq_sleep_tb;

  // The tests take about 350 cycles together
  localparam int WATCHDOG_CYCLES = 1500;

  logic                        clk_i;
  logic                        rst_ni;
  logic [irq_pkg::NUM_IRQ-1:0] irq_i;
  irq_pkg::csr_state_t         csr_i;
  logic                        debug_mode_i;
  sleep_pkg::wb_instr_t        wb_i;
  sleep_pkg::bus_status_t      bus_i;
  sleep_pkg::wake_req_t        wake_i;
  irq_pkg::irq_take_t          take_o;
  logic [irq_pkg::NUM_IRQ-1:0] mip_o;
  logic                        core_sleep_o;
  logic                        wfi_retire_o;

  int          test_errors;
  int          total_errors;
  int          tests_run;
  logic [31:0] rng_state;

  irq_sleep_unit u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .irq_i        (irq_i),
    .csr_i        (csr_i),
    .debug_mode_i (debug_mode_i),
    .wb_i         (wb_i),
    .bus_i        (bus_i),
    .wake_i       (wake_i),
    .take_o       (take_o),
    .mip_o        (mip_o),
    .core_sleep_o (core_sleep_o),
    .wfi_retire_o (wfi_retire_o)
  );

  always #20 clk_i = ~clk_i;

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the test sequence hung", WATCHDOG_CYCLES);
    $display("Errors found");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Helpers and reference model
  // ----------------------------------------------------------------------

  // Move past the next rising edge to the drive point
  task automatic tick(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("%-16s finished, %0d failed checks", name, test_errors);
    total_errors += test_errors;
    test_errors = 0;
    tests_run++;
  endtask

  // Quiet core with no lines, no WFI in writeback and an idle bus
  task automatic drive_idle();
    irq_i            = '0;
    csr_i            = '0;
    csr_i.priv_lvl   = irq_pkg::priv_m;
    debug_mode_i     = 1'b0;
    wb_i             = '0;
    wb_i.mpu_ok      = 1'b1;
    bus_i            = '0;
    bus_i.wbuf_empty = 1'b1;
    wake_i           = '0;
  endtask

  // Winner of a pending-and-enabled set as {valid, id}
  function automatic logic [5:0] ref_winner(input logic [31:0] pend);
    for (int i = 31; i >= 16; i--) begin
      if (pend[i]) begin
        return {1'b1, irq_pkg::irq_id_t'(i)};
      end
    end
    if (pend[11]) begin
      return {1'b1, 5'd11};
    end
    if (pend[3]) begin
      return {1'b1, 5'd3};
    end
    if (pend[7]) begin
      return {1'b1, 5'd7};
    end
    return 6'd0;
  endfunction

  `include "irq_sleep_tasks.svh"

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    rng_state    = 32'h21d45abe;
    drive_idle();
    // Active lines, open enables and a WFI in writeback while reset is held
    irq_i             = '1;
    csr_i.mie         = '1;
    csr_i.mstatus_mie = 1'b1;
    present_wfi(sleep_pkg::WFI_INSTR);
    repeat (5) @(posedge clk_i);
    #1;
    check_val("mip_o", mip_o, 32'h0);
    check_val("take_o.ack", take_o.ack, 32'h0);
    check_val("core_sleep_o", core_sleep_o, 32'h0);
    check_val("wfi_retire_o", wfi_retire_o, 32'h0);
    drive_idle();
    rst_ni = 1'b1;
    end_test("reset");

    test_pending_capture();
    test_arbitration();
    test_gating();
    test_sleep_entry();
    test_back_pressure();
    test_wake_retire();

    $display("Tests run: %0d, failed checks: %0d", tests_run, total_errors);
    if (total_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+tb
hw/irq_pkg.sv
hw/sleep_pkg.sv
hw/irq_arbiter.sv
hw/wfi_qualify.sv
hw/sleep_ctrl.sv
hw/irq_sleep_unit.sv
tb/irq_sleep_tb.sv
